//--- all.f
+incdir+include
logic/decodePkg.sv
logic/fdRegister.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/branchUnit.sv
logic/decodeStage.sv
bench/decodeStageTb.sv

//--- bench/decodeStageTb.sv
// expects one table row per cycle; expected control words are rebuilt here from the ISA table
`timescale 1ns/1ps

module decodeStageTb import decodePkg::*; ();

  typedef struct {
    word_t       instr;
    word_t       pc;
    logic        stall;
    logic        fwdA;
    logic        fwdB;
    word_t       aluOut;
    word_t       expInstr; // word that should sit in decode
    word_t       expPc;
    logic [16:0] expCtrl;
    logic        expPcSrc;
  } row_t;

  // control words {regWrite, wbSrc, memWrite, aluCtrl, aluSrc, regDst, branch, jump, mult}
  localparam logic [16:0] C_NOP   = '0;
  localparam logic [16:0] C_ADD   = {1'b1, 4'b0001, 1'b0, 3'd2, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_SUB   = {1'b1, 4'b0001, 1'b0, 3'd5, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_AND   = {1'b1, 4'b0001, 1'b0, 3'd0, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_OR    = {1'b1, 4'b0001, 1'b0, 3'd1, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_XOR   = {1'b1, 4'b0001, 1'b0, 3'd3, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_XNOR  = {1'b1, 4'b0001, 1'b0, 3'd4, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_SLT   = {1'b1, 4'b0001, 1'b0, 3'd6, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_MULT  = {1'b0, 4'b0000, 1'b0, 3'd0, 2'd0, 1'b0, 2'b00, 3'b011};
  localparam logic [16:0] C_MULTU = {1'b0, 4'b0000, 1'b0, 3'd0, 2'd0, 1'b0, 2'b00, 3'b010};
  localparam logic [16:0] C_MFHI  = {1'b1, 4'b0100, 1'b0, 3'd0, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_MFLO  = {1'b1, 4'b1000, 1'b0, 3'd0, 2'd0, 1'b1, 2'b00, 3'b000};
  localparam logic [16:0] C_ADDI  = {1'b1, 4'b0001, 1'b0, 3'd2, 2'd1, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_ANDI  = {1'b1, 4'b0001, 1'b0, 3'd0, 2'd2, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_ORI   = {1'b1, 4'b0001, 1'b0, 3'd1, 2'd2, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_XORI  = {1'b1, 4'b0001, 1'b0, 3'd3, 2'd2, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_SLTI  = {1'b1, 4'b0001, 1'b0, 3'd6, 2'd1, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_LUI   = {1'b1, 4'b0001, 1'b0, 3'd7, 2'd1, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_LW    = {1'b1, 4'b0010, 1'b0, 3'd2, 2'd1, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_SW    = {1'b0, 4'b0000, 1'b1, 3'd2, 2'd1, 1'b0, 2'b00, 3'b000};
  localparam logic [16:0] C_JAL   = {1'b1, 4'b0000, 1'b0, 3'd0, 2'd0, 1'b0, 2'b00, 3'b100};
  localparam logic [16:0] C_BEQ   = {1'b0, 4'b0000, 1'b0, 3'd5, 2'd0, 1'b0, 2'b01, 3'b000};
  localparam logic [16:0] C_BNE   = {1'b0, 4'b0000, 1'b0, 3'd5, 2'd0, 1'b0, 2'b10, 3'b000};

  logic clk, reset, stallD, forwardAD, forwardBD, regWriteW;
  word_t instrF, pcPlus4F, aluOutM, resultW;
  regAddr_t writeRegW;
  logic regWriteD, memWriteD, regDstD, jumpD, multStartD, multSgnD, pcSrcD;
  wbSrc_t wbSrcD;
  aluCtrl_t aluCtrlD;
  aluSrc_t aluSrcD;
  branchSel_t branchD;
  regAddr_t rsD, rtD, rdD;
  word_t signImmD, zeroImmD, rd1D, rd2D, pcPlus4D, pcBranchD;
  logic [27:0] jumpDstD;

  row_t  rows[$];
  word_t regVal[32]; // model of the register file
  word_t pcNext;
  int    errors;
  int    numRows;

  decodeStage dut_i (.*);

  always #50 clk = ~clk;

  function automatic word_t rtype(logic [5:0] fn, int rs, int rt, int rd);
    return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic word_t itype(logic [5:0] op, int rs, int rt, logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  // kind 0 decodes the row itself, 1 is flushed to a nop, 2 holds the previous row
  function automatic void addRow(word_t instr, int kind, logic stall, logic fa, logic fb,
                                 word_t aluOut, logic [16:0] ctrl, logic pcSrc);
    row_t r;
    r.instr = instr;
    r.pc = pcNext;
    r.stall = stall;
    r.fwdA = fa;
    r.fwdB = fb;
    r.aluOut = aluOut;
    r.expInstr = (kind == 0) ? instr : (kind == 1) ? '0 : rows[$].expInstr;
    r.expPc = (kind == 0) ? pcNext : (kind == 1) ? '0 : rows[$].expPc;
    r.expCtrl = ctrl;
    r.expPcSrc = pcSrc;
    rows.push_back(r);
    pcNext += 4;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkRow(input int k);
    row_t  e;
    word_t sImm, a, b;
    e = rows[k];
    sImm = $signed(e.expInstr[15:0]);
    a = e.fwdA ? e.aluOut : regVal[e.expInstr[25:21]];
    b = e.fwdB ? e.aluOut : regVal[e.expInstr[20:16]];
    checkValue($sformatf("row %0d control", k), 32'({regWriteD, wbSrcD, memWriteD,
      aluCtrlD, aluSrcD, regDstD, branchD, jumpD, multStartD, multSgnD}), 32'(e.expCtrl));
    checkValue($sformatf("row %0d pcSrcD", k), 32'(pcSrcD), 32'(e.expPcSrc));
    checkValue($sformatf("row %0d fields", k), 32'({rsD, rtD, rdD}), 32'(e.expInstr[25:11]));
    checkValue($sformatf("row %0d signImmD", k), signImmD, sImm);
    checkValue($sformatf("row %0d zeroImmD", k), zeroImmD, 32'(e.expInstr[15:0]));
    checkValue($sformatf("row %0d rd1D", k), rd1D, a);
    checkValue($sformatf("row %0d rd2D", k), rd2D, b);
    checkValue($sformatf("row %0d pcPlus4D", k), pcPlus4D, e.expPc);
    checkValue($sformatf("row %0d pcBranchD", k), pcBranchD, e.expPc + (sImm << 2));
    checkValue($sformatf("row %0d jumpDstD", k), 32'(jumpDstD), 32'(e.expInstr[25:0]) * 4);
  endtask

  task automatic buildTable();
    pcNext = 32'h0040_0004;
    for (int r = 1; r <= 16; r++)
      addRow(rtype(FN_OR, r, 32 - r, 3), 0, 0, 0, 0, '0, C_OR, 0); // reads every register
    addRow(rtype(FN_ADD, 0, 0, 3), 0, 0, 0, 0, '0, C_ADD, 0); // $0 stays zero after a write
    addRow(rtype(FN_SUB, 4, 5, 6), 0, 0, 0, 0, '0, C_SUB, 0);
    addRow(rtype(FN_AND, 7, 8, 9), 0, 0, 0, 0, '0, C_AND, 0);
    addRow(rtype(FN_XOR, 1, 2, 3), 0, 0, 0, 0, '0, C_XOR, 0);
    addRow(rtype(FN_XNOR, 1, 2, 3), 0, 0, 0, 0, '0, C_XNOR, 0);
    addRow(rtype(FN_SLT, 1, 2, 3), 0, 0, 0, 0, '0, C_SLT, 0);
    addRow(rtype(FN_MULT, 1, 2, 0), 0, 0, 0, 0, '0, C_MULT, 0);
    addRow(rtype(FN_MULTU, 1, 2, 0), 0, 0, 0, 0, '0, C_MULTU, 0);
    addRow(rtype(FN_MFHI, 0, 0, 5), 0, 0, 0, 0, '0, C_MFHI, 0);
    addRow(rtype(FN_MFLO, 0, 0, 5), 0, 0, 0, 0, '0, C_MFLO, 0);
    addRow(rtype(FN_NOP, 0, 0, 0), 0, 0, 0, 0, '0, C_NOP, 0);
    addRow(rtype(6'b111111, 1, 2, 3), 0, 0, 0, 0, '0, C_NOP, 0); // unknown funct
    addRow(itype(6'b111111, 1, 2, 16'h1234), 0, 0, 0, 0, '0, C_NOP, 0); // unknown opcode
    addRow(itype(OP_ADDI, 1, 2, 16'h8004), 0, 0, 0, 0, '0, C_ADDI, 0);
    addRow(itype(OP_ANDI, 3, 4, 16'hf0f0), 0, 0, 0, 0, '0, C_ANDI, 0);
    addRow(itype(OP_ORI, 5, 6, 16'h00ff), 0, 0, 0, 0, '0, C_ORI, 0);
    addRow(itype(OP_XORI, 7, 8, 16'h8001), 0, 0, 0, 0, '0, C_XORI, 0);
    addRow(itype(OP_SLTI, 9, 10, 16'hfffe), 0, 0, 0, 0, '0, C_SLTI, 0);
    addRow(itype(OP_LUI, 0, 11, 16'habcd), 0, 0, 0, 0, '0, C_LUI, 0);
    addRow(itype(OP_LW, 29, 12, 16'h0010), 0, 0, 0, 0, '0, C_LW, 0);
    addRow(itype(OP_SW, 29, 13, 16'hfff0), 0, 0, 0, 0, '0, C_SW, 0);
    // branches and the flush after a taken one
    addRow(itype(OP_BEQ, 1, 1, 16'hfffd), 0, 0, 0, 0, '0, C_BEQ, 1);
    addRow(rtype(FN_ADD, 1, 2, 3), 1, 0, 0, 0, '0, C_NOP, 0);
    addRow(itype(OP_BNE, 1, 1, 16'h0008), 0, 0, 0, 0, '0, C_BNE, 0);
    addRow(itype(OP_BEQ, 4, 5, 16'h0020), 0, 0, 1, 1, 32'h1234, C_BEQ, 1);
    addRow(rtype(FN_SUB, 1, 2, 3), 1, 0, 0, 0, '0, C_NOP, 0);
    addRow(itype(OP_BNE, 0, 0, 16'h7fff), 0, 0, 1, 0, 32'h7, C_BNE, 1);
    addRow(rtype(FN_AND, 1, 2, 3), 1, 0, 0, 0, '0, C_NOP, 0);
    addRow({OP_JAL, 26'h2abcdef}, 0, 0, 0, 0, '0, C_JAL, 0);
    addRow(rtype(FN_OR, 1, 2, 3), 1, 0, 0, 0, '0, C_NOP, 0);
    // plain stall holds the decoded word
    addRow(rtype(FN_OR, 6, 7, 8), 0, 0, 0, 0, '0, C_OR, 0);
    addRow(rtype(FN_XOR, 1, 2, 3), 2, 1, 0, 0, '0, C_OR, 0);
    addRow(itype(OP_ANDI, 2, 3, 16'h0f0f), 0, 0, 0, 0, '0, C_ANDI, 0);
    // taken branch while stalled clears twice
    addRow(itype(OP_BEQ, 2, 2, 16'h0004), 0, 0, 0, 0, '0, C_BEQ, 1);
    addRow(rtype(FN_ADD, 1, 2, 3), 1, 1, 0, 0, '0, C_NOP, 0);
    addRow(rtype(FN_SUB, 1, 2, 3), 1, 0, 0, 0, '0, C_NOP, 0);
    addRow(itype(OP_ORI, 3, 4, 16'h5a5a), 0, 0, 0, 0, '0, C_ORI, 0);
  endtask

  initial
  begin
    int seedSink;
    clk = 0;
    reset = 1;
    instrF = '0;
    pcPlus4F = '0;
    stallD = 0;
    forwardAD = 0;
    forwardBD = 0;
    aluOutM = '0;
    regWriteW = 0;
    writeRegW = '0;
    resultW = '0;
    errors = 0;
    seedSink = $urandom(32'h889591eb);
    buildTable();
    numRows = rows.size();
    repeat (16) @(posedge clk);
    reset <= 0;
    @(negedge clk);
    checkValue("control after reset", 32'({regWriteD, wbSrcD, memWriteD, aluCtrlD, aluSrcD,
      regDstD, branchD, jumpD, multStartD, multSgnD, pcSrcD}), 32'h0);
    // fill registers through writeback, $0 included
    for (int r = 0; r < 32; r++)
    begin
      @(posedge clk);
      regVal[r] = (r == 0) ? '0 : $urandom();
      regWriteW <= 1;
      writeRegW <= regAddr_t'(r);
      resultW <= (r == 0) ? 32'hdeadbeef : regVal[r];
    end
    @(posedge clk);
    regWriteW <= 0;
    // row i enters at this edge; row i-1 is in decode until the next one
    for (int i = 0; i <= numRows; i++)
    begin
      @(posedge clk);
      if (i < numRows)
      begin
        instrF <= rows[i].instr;
        pcPlus4F <= rows[i].pc;
        stallD <= rows[i].stall;
      end
      if (i > 0)
      begin
        forwardAD <= rows[i-1].fwdA;
        forwardBD <= rows[i-1].fwdB;
        aluOutM <= rows[i-1].aluOut;
      end
      @(negedge clk);
      if (i > 0)
        checkRow(i - 1);
    end
    $display("%0d errors in %0d table rows", errors, numRows);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // watchdog, sized from the table length
  initial
  begin
    #1;
    #((numRows + 64) * 100);
    $display("timeout, the test sequence did not finish");
    $display("Something failed");
    $finish;
  end

endmodule

//--- include/isaCodes.svh
// MIPS32-style opcode and funct values for the decoded subset only; 100111 is xnor here, not nor
`ifndef ISA_CODES_SVH
`define ISA_CODES_SVH

// primary opcode field, instr[31:26]
localparam logic [5:0] OP_RTYPE = 6'b000000;
localparam logic [5:0] OP_JAL   = 6'b000011;
localparam logic [5:0] OP_BEQ   = 6'b000100;
localparam logic [5:0] OP_BNE   = 6'b000101;
localparam logic [5:0] OP_ADDI  = 6'b001000;
localparam logic [5:0] OP_SLTI  = 6'b001010;
localparam logic [5:0] OP_ANDI  = 6'b001100;
localparam logic [5:0] OP_ORI   = 6'b001101;
localparam logic [5:0] OP_XORI  = 6'b001110;
localparam logic [5:0] OP_LUI   = 6'b001111;
localparam logic [5:0] OP_LW    = 6'b100011;
localparam logic [5:0] OP_SW    = 6'b101011;

// funct field of R-type, instr[5:0]
localparam logic [5:0] FN_NOP   = 6'b000000;
localparam logic [5:0] FN_MFHI  = 6'b010000;
localparam logic [5:0] FN_MFLO  = 6'b010010;
localparam logic [5:0] FN_MULT  = 6'b011000;
localparam logic [5:0] FN_MULTU = 6'b011001;
localparam logic [5:0] FN_ADD   = 6'b100000;
localparam logic [5:0] FN_SUB   = 6'b100010;
localparam logic [5:0] FN_AND   = 6'b100100;
localparam logic [5:0] FN_OR    = 6'b100101;
localparam logic [5:0] FN_XOR   = 6'b100110;
localparam logic [5:0] FN_XNOR  = 6'b100111;
localparam logic [5:0] FN_SLT   = 6'b101010;

// writeback source, one bit per source
localparam logic [3:0] WB_LINK  = 4'b0000; // with regWrite set, write pc+4
localparam logic [3:0] WB_ALU   = 4'b0001;
localparam logic [3:0] WB_MEM   = 4'b0010;
localparam logic [3:0] WB_HI    = 4'b0100;
localparam logic [3:0] WB_LO    = 4'b1000;

`endif

//--- logic/branchUnit.sv
// forwarding only from the memory stage; an execute-stage dependency must be stalled outside
`timescale 1ns/1ps

module branchUnit import decodePkg::*; (
  input  word_t       rd1,
  input  word_t       rd2,
  input  word_t       aluOutM,
  input  word_t       pcPlus4D,
  input  word_t       signImm,
  input  logic        forwardA,
  input  logic        forwardB,
  input  branchSel_t  branch,
  input  logic [25:0] jumpIndex,
  output word_t       srcA,
  output word_t       srcB,
  output word_t       pcBranch,
  output logic [27:0] jumpDst,
  output logic        pcSrc
);

  logic sameOps;

  // operands, newest value from memory stage wins
  assign srcA = forwardA ? aluOutM : rd1;
  assign srcB = forwardB ? aluOutM : rd2;

  // early resolution in decode
  assign sameOps = (srcA == srcB);
  assign pcSrc   = ((branch == BR_BEQ) && sameOps) ||
                   ((branch == BR_BNE) && !sameOps);

  // word offset relative to pc+4
  assign pcBranch = pcPlus4D + {signImm[29:0], 2'b00};

  assign jumpDst = {jumpIndex, 2'b00}; // upper pc bits added in fetch

  // both kinds at once would silently resolve as not taken
  always_comb
  begin
    oneBranch: assert (branch != 2'b11)
      else $error("beq and bne selected together");
  end

endmodule

//--- logic/decodePkg.sv
// widths are fixed by the 32-bit instruction set; the include path must reach include/
package decodePkg;

  typedef logic [31:0] word_t;      // data word, instruction or address
  typedef logic [4:0]  regAddr_t;   // register number
  typedef logic [2:0]  aluCtrl_t;
  typedef logic [1:0]  aluSrc_t;
  typedef logic [1:0]  branchSel_t; // bit 0 beq, bit 1 bne
  typedef logic [3:0]  wbSrc_t;

  `include "isaCodes.svh"

  // alu operation codes, as expected by execute
  localparam aluCtrl_t ALU_AND  = 3'd0;
  localparam aluCtrl_t ALU_OR   = 3'd1;
  localparam aluCtrl_t ALU_ADD  = 3'd2;
  localparam aluCtrl_t ALU_XOR  = 3'd3;
  localparam aluCtrl_t ALU_XNOR = 3'd4;
  localparam aluCtrl_t ALU_SUB  = 3'd5;
  localparam aluCtrl_t ALU_SLT  = 3'd6;
  localparam aluCtrl_t ALU_LUI  = 3'd7;

  // second alu operand
  localparam aluSrc_t SRC_REG  = 2'd0;
  localparam aluSrc_t SRC_SIMM = 2'd1; // sign-extended immediate
  localparam aluSrc_t SRC_ZIMM = 2'd2; // zero-extended immediate

  localparam branchSel_t BR_NONE = 2'b00;
  localparam branchSel_t BR_BEQ  = 2'b01;
  localparam branchSel_t BR_BNE  = 2'b10;

endpackage

//--- logic/decodeStage.sv
// hazard detection and forward selects come from outside; jumpDstD lacks the upper pc bits
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  word_t       instrF,
  input  word_t       pcPlus4F,
  input  logic        stallD,
  input  logic        forwardAD,
  input  logic        forwardBD,
  input  word_t       aluOutM,
  input  logic        regWriteW,
  input  regAddr_t    writeRegW,
  input  word_t       resultW,
  output logic        regWriteD,
  output logic        memWriteD,
  output logic        regDstD,
  output logic        jumpD,
  output logic        multStartD,
  output logic        multSgnD,
  output wbSrc_t      wbSrcD,
  output aluCtrl_t    aluCtrlD,
  output aluSrc_t     aluSrcD,
  output branchSel_t  branchD,
  output regAddr_t    rsD,
  output regAddr_t    rtD,
  output regAddr_t    rdD,
  output word_t       signImmD,
  output word_t       zeroImmD,
  output word_t       rd1D,
  output word_t       rd2D,
  output word_t       pcPlus4D,
  output word_t       pcBranchD,
  output logic [27:0] jumpDstD,
  output logic        pcSrcD
);

  word_t       instrD;
  word_t       rfRd1;
  word_t       rfRd2;
  logic        flushD;
  logic [15:0] immD;
  logic [25:0] jumpIndexD;

  // instruction fields
  assign rsD        = instrD[25:21];
  assign rtD        = instrD[20:16];
  assign rdD        = instrD[15:11];
  assign immD       = instrD[15:0];
  assign jumpIndexD = instrD[25:0];

  assign signImmD = {{16{immD[15]}}, immD};
  assign zeroImmD = {16'h0000, immD};

  // wrong-path fetch after jal or a taken branch
  assign flushD = jumpD || (pcSrcD && (branchD != BR_NONE));

  fdRegister fdReg_i (
    .clk(clk), .reset(reset), .stallD(stallD), .flush(flushD),
    .instrF(instrF), .pcPlus4F(pcPlus4F), .instrD(instrD), .pcPlus4D(pcPlus4D)
  );

  instrDecoder decoder_i (
    .op(instrD[31:26]), .funct(instrD[5:0]),
    .regWriteD(regWriteD), .memWriteD(memWriteD), .regDstD(regDstD), .jumpD(jumpD),
    .multStartD(multStartD), .multSgnD(multSgnD), .wbSrcD(wbSrcD),
    .aluCtrlD(aluCtrlD), .aluSrcD(aluSrcD), .branchD(branchD)
  );

  regFile regs_i (
    .clk(clk), .reset(reset), .we(regWriteW), .ra1(rsD), .ra2(rtD),
    .wa(writeRegW), .wd(resultW), .rd1(rfRd1), .rd2(rfRd2)
  );

  branchUnit branch_i (
    .rd1(rfRd1), .rd2(rfRd2), .aluOutM(aluOutM), .pcPlus4D(pcPlus4D),
    .signImm(signImmD), .forwardA(forwardAD), .forwardB(forwardBD),
    .branch(branchD), .jumpIndex(jumpIndexD), .srcA(rd1D), .srcB(rd2D),
    .pcBranch(pcBranchD), .jumpDst(jumpDstD), .pcSrc(pcSrcD)
  );

endmodule

//--- logic/fdRegister.sv
// flush must already include the branch-taken and jump terms; flush beats stall
`timescale 1ns/1ps

module fdRegister import decodePkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  stallD,
  input  logic  flush,
  input  word_t instrF,
  input  word_t pcPlus4F,
  output word_t instrD,
  output word_t pcPlus4D
);

  logic pendFlush; // flush seen while stalled, clear once more

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      instrD    <= '0;
      pcPlus4D  <= '0;
      pendFlush <= 1'b0;
    end
    else if (flush || pendFlush)
    begin
      instrD    <= '0; // all-zero word decodes as nop
      pcPlus4D  <= '0;
      pendFlush <= flush && stallD;
    end
    else if (!stallD)
    begin
      instrD   <= instrF;
      pcPlus4D <= pcPlus4F;
    end
  end

  // a flush clears decode, and once more at the next edge if it came during a stall
  flushClears: assert property (@(posedge clk) disable iff (reset)
    ($past(flush) || $past(flush && stallD, 2)) |-> instrD == '0)
    else $error("instrD not cleared after flush");

endmodule

//--- logic/instrDecoder.sv
// purely combinational; unsupported opcodes and functs give an all-zero control word
`timescale 1ns/1ps

module instrDecoder import decodePkg::*; (
  input  logic [5:0]  op,
  input  logic [5:0]  funct,
  output logic        regWriteD,
  output logic        memWriteD,
  output logic        regDstD,
  output logic        jumpD,
  output logic        multStartD,
  output logic        multSgnD,
  output wbSrc_t      wbSrcD,
  output aluCtrl_t    aluCtrlD,
  output aluSrc_t     aluSrcD,
  output branchSel_t  branchD
);

  logic [16:0] ctrl;

  // field order of the control word
  assign {regWriteD, wbSrcD, memWriteD, aluCtrlD, aluSrcD,
          regDstD, branchD, jumpD, multStartD, multSgnD} = ctrl;

  always_comb
  begin
    ctrl = '0;
    if (op == OP_RTYPE)
    begin
      case (funct)
        FN_NOP:   ctrl = '0;
        FN_ADD:   ctrl = {1'b1, WB_ALU, 1'b0, ALU_ADD, SRC_REG, 1'b1, BR_NONE, 3'b000};
        FN_SUB:   ctrl = {1'b1, WB_ALU, 1'b0, ALU_SUB, SRC_REG, 1'b1, BR_NONE, 3'b000};
        FN_AND:   ctrl = {1'b1, WB_ALU, 1'b0, ALU_AND, SRC_REG, 1'b1, BR_NONE, 3'b000};
        FN_OR:    ctrl = {1'b1, WB_ALU, 1'b0, ALU_OR, SRC_REG, 1'b1, BR_NONE, 3'b000};
        FN_XOR:   ctrl = {1'b1, WB_ALU, 1'b0, ALU_XOR, SRC_REG, 1'b1, BR_NONE, 3'b000};
        FN_XNOR:  ctrl = {1'b1, WB_ALU, 1'b0, ALU_XNOR, SRC_REG, 1'b1, BR_NONE, 3'b000};
        FN_SLT:   ctrl = {1'b1, WB_ALU, 1'b0, ALU_SLT, SRC_REG, 1'b1, BR_NONE, 3'b000};
        // multiplier start, no register write from decode
        FN_MULT:  ctrl = {1'b0, 4'b0000, 1'b0, 3'b000, SRC_REG, 1'b0, BR_NONE, 3'b011};
        FN_MULTU: ctrl = {1'b0, 4'b0000, 1'b0, 3'b000, SRC_REG, 1'b0, BR_NONE, 3'b010};
        FN_MFHI:  ctrl = {1'b1, WB_HI, 1'b0, 3'b000, SRC_REG, 1'b1, BR_NONE, 3'b000};
        FN_MFLO:  ctrl = {1'b1, WB_LO, 1'b0, 3'b000, SRC_REG, 1'b1, BR_NONE, 3'b000};
        default:  ctrl = '0;
      endcase
    end
    else
    begin
      case (op)
        OP_ADDI: ctrl = {1'b1, WB_ALU, 1'b0, ALU_ADD, SRC_SIMM, 1'b0, BR_NONE, 3'b000};
        OP_ANDI: ctrl = {1'b1, WB_ALU, 1'b0, ALU_AND, SRC_ZIMM, 1'b0, BR_NONE, 3'b000};
        OP_ORI:  ctrl = {1'b1, WB_ALU, 1'b0, ALU_OR, SRC_ZIMM, 1'b0, BR_NONE, 3'b000};
        OP_XORI: ctrl = {1'b1, WB_ALU, 1'b0, ALU_XOR, SRC_ZIMM, 1'b0, BR_NONE, 3'b000};
        OP_SLTI: ctrl = {1'b1, WB_ALU, 1'b0, ALU_SLT, SRC_SIMM, 1'b0, BR_NONE, 3'b000};
        OP_LUI:  ctrl = {1'b1, WB_ALU, 1'b0, ALU_LUI, SRC_SIMM, 1'b0, BR_NONE, 3'b000};
        OP_LW:   ctrl = {1'b1, WB_MEM, 1'b0, ALU_ADD, SRC_SIMM, 1'b0, BR_NONE, 3'b000};
        OP_SW:   ctrl = {1'b0, 4'b0000, 1'b1, ALU_ADD, SRC_SIMM, 1'b0, BR_NONE, 3'b000};
        // link write of pc+4, register choice left to later stages
        OP_JAL:  ctrl = {1'b1, WB_LINK, 1'b0, 3'b000, SRC_REG, 1'b0, BR_NONE, 3'b100};
        OP_BEQ:  ctrl = {1'b0, 4'b0000, 1'b0, ALU_SUB, SRC_REG, 1'b0, BR_BEQ, 3'b000};
        OP_BNE:  ctrl = {1'b0, 4'b0000, 1'b0, ALU_SUB, SRC_REG, 1'b0, BR_BNE, 3'b000};
        default: ctrl = '0;
      endcase
    end
  end

endmodule

//--- logic/regFile.sv
// write on falling edge so a same-cycle read sees new data; register 0 is hardwired to zero
`timescale 1ns/1ps

module regFile import decodePkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     we,
  input  regAddr_t ra1,
  input  regAddr_t ra2,
  input  regAddr_t wa,
  input  word_t    wd,
  output word_t    rd1,
  output word_t    rd2
);

  word_t regs [32];

  // writeback port, half a cycle ahead of the next rising edge
  always_ff @(negedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we && wa != '0)
    begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 != '0) ? regs[ra1] : '0;
  assign rd2 = (ra2 != '0) ? regs[ra2] : '0; // $zero

endmodule

//--- run.sh
#!/bin/bash
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module decodeStageTb -f all.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/simv)
simStatus=$?
echo "$simOut"

if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
